// ==== source/dma_pkg.sv ====
// dma package
// bus widths, register map, AHB-Lite codes and the control/status word views
`default_nettype none

package dma_pkg;

  localparam int addr_w = 32;                  // both buses
  localparam int data_w = 32;                  // both buses
  localparam int len_w  = 4;                   // word count, at most 15 per run

  ////////////////////////////////////////////////////////////
  // register map, byte offsets in the slave window
  localparam logic [3:0] reg_src_off  = 4'h0;  // source address
  localparam logic [3:0] reg_dst_off  = 4'h4;  // destination address
  localparam logic [3:0] reg_len_off  = 4'h8;  // transfer length in words
  localparam logic [3:0] reg_ctrl_off = 4'hC;  // command on write, status on read

  ////////////////////////////////////////////////////////////
  // AHB-Lite encodings
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [2:0] hsize_word    = 3'b010; // 32 bit
  localparam logic [2:0] hburst_single = 3'b000;
  localparam logic       hresp_okay    = 1'b0;
  localparam logic       hresp_error   = 1'b1;

  // controller fsm
  localparam logic [1:0] st_idle   = 2'b00;
  localparam logic [1:0] st_read   = 2'b01;
  localparam logic [1:0] st_write  = 2'b10;
  localparam logic [1:0] st_finish = 2'b11;

  typedef struct packed {
    logic [data_w-3:0]       rsvd;             // reads back as zero
    logic                    clear_status;     // drop done and error
    logic                    start;            // kick off a run
  } ctrl_cmd_s;

  typedef struct packed {
    logic [data_w-len_w-5:0] rsvd_hi;
    logic [len_w-1:0]        remaining;        // words not yet written
    logic                    rsvd_3;
    logic                    error;            // bus error seen
    logic                    done;             // run ended
    logic                    busy;             // engine running
  } ctrl_status_s;

  // same word, decoded by direction of access
  typedef union packed {
    ctrl_cmd_s    cmd;                         // write view
    ctrl_status_s status;                      // read view
  } ctrl_word_u;

endpackage

`default_nettype wire

// ==== source/dma_regs.sv ====
// dma register block
// AHB-Lite slave holding source, destination, length and the control/status word
`timescale 1ns/1ps
`default_nettype none

module dma_regs (
  input  logic                       hclk_i,
  input  logic                       arst_n_i,
  input  logic                       hsel_i,
  input  logic [dma_pkg::addr_w-1:0] haddr_i,
  input  logic [1:0]                 htrans_i,
  input  logic                       hwrite_i,
  input  logic [dma_pkg::data_w-1:0] hwdata_i,
  input  logic                       hready_i,
  output logic [dma_pkg::data_w-1:0] hrdata_o,
  output logic                       hready_o,
  output logic                       hresp_o,
  input  logic                       busy_i,
  input  logic                       done_i,
  input  logic                       error_i,
  input  logic [dma_pkg::len_w-1:0]  remaining_i,
  output logic                       start_o,
  output logic                       clear_o,
  output logic [dma_pkg::addr_w-1:0] src_addr_o,
  output logic [dma_pkg::addr_w-1:0] dst_addr_o,
  output logic [dma_pkg::len_w-1:0]  len_o
);
  import dma_pkg::*;

  logic       ap_valid_q;                      // data phase of an accepted transfer
  logic       ap_write_q;
  logic [3:0] ap_off_q;                        // register offset
  logic       wr_en;
  logic       rd_en;
  ctrl_word_u wr_word;                         // cmd view of hwdata
  ctrl_word_u rd_word;                         // status view for readback

  ////////////////////////////////////////////////////////////
  // address phase capture
  always_ff @(posedge hclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ap_valid_q <= 1'b0;
      ap_write_q <= 1'b0;
      ap_off_q   <= '0;
    end else if (hready_i) begin               // bus moves only when ready
      ap_valid_q <= hsel_i && (htrans_i == htrans_nonseq);
      ap_write_q <= hwrite_i;
      ap_off_q   <= haddr_i[3:0];
    end
  end

  assign wr_en   = ap_valid_q && ap_write_q && hready_i; // write data valid now
  assign rd_en   = ap_valid_q && !ap_write_q;
  assign wr_word = hwdata_i;

  // command decode, pulses in the data phase
  assign start_o = wr_en && (ap_off_q == reg_ctrl_off) && wr_word.cmd.start && !busy_i;
  assign clear_o = wr_en && (ap_off_q == reg_ctrl_off) && wr_word.cmd.clear_status;

  ////////////////////////////////////////////////////////////
  // configuration registers, frozen while a run is active
  always_ff @(posedge hclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_addr_o <= '0;
      dst_addr_o <= '0;
      len_o      <= '0;
    end else if (wr_en && !busy_i) begin
      case (ap_off_q)
        reg_src_off: src_addr_o <= hwdata_i;
        reg_dst_off: dst_addr_o <= hwdata_i;
        reg_len_off: len_o      <= hwdata_i[len_w-1:0];
        default: ;                             // ctrl handled by the pulses
      endcase
    end
  end

  // readback
  always_comb begin
    rd_word                  = '0;
    rd_word.status.busy      = busy_i;
    rd_word.status.done      = done_i;
    rd_word.status.error     = error_i;
    rd_word.status.remaining = remaining_i;
    hrdata_o                 = '0;
    if (rd_en) begin
      case (ap_off_q)
        reg_src_off:  hrdata_o = src_addr_o;
        reg_dst_off:  hrdata_o = dst_addr_o;
        reg_len_off:  hrdata_o = {{(data_w-len_w){1'b0}}, len_o};
        reg_ctrl_off: hrdata_o = rd_word;
        default:      hrdata_o = '0;
      endcase
    end
  end

  assign hready_o = 1'b1;                      // zero wait states
  assign hresp_o  = hresp_okay;

  // a start only reaches an idle engine, which runs or ends on the next cycle
  a_start_idle: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    start_o |-> !busy_i ##1 (busy_i || done_i));

endmodule

`default_nettype wire

// ==== source/dma_ctrl.sv ====
// dma controller
// fsm that reads then writes one word at a time and counts the words left
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl (
  input  logic                       hclk_i,
  input  logic                       arst_n_i,
  input  logic                       start_i,
  input  logic                       clear_i,
  input  logic [dma_pkg::addr_w-1:0] src_addr_i,
  input  logic [dma_pkg::addr_w-1:0] dst_addr_i,
  input  logic [dma_pkg::len_w-1:0]  len_i,
  input  logic                       xfer_ack_i,
  input  logic [dma_pkg::data_w-1:0] xfer_rdata_i,
  input  logic                       xfer_err_i,
  output logic                       xfer_req_o,
  output logic                       xfer_write_o,
  output logic [dma_pkg::addr_w-1:0] xfer_addr_o,
  output logic [dma_pkg::data_w-1:0] xfer_wdata_o,
  output logic                       busy_o,
  output logic                       done_o,
  output logic                       error_o,
  output logic [dma_pkg::len_w-1:0]  remaining_o
);
  import dma_pkg::*;

  logic [1:0]        state_q;
  logic [addr_w-1:0] rd_ptr_q;                 // next source word
  logic [addr_w-1:0] wr_ptr_q;                 // next destination word
  logic [data_w-1:0] data_q;                   // word between read and write
  logic [len_w-1:0]  remain_q;

  ////////////////////////////////////////////////////////////
  // fsm, status flags and word count
  always_ff @(posedge hclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= st_idle;
      done_o   <= 1'b0;
      error_o  <= 1'b0;
      remain_q <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start_i) begin
            error_o  <= 1'b0;
            remain_q <= len_i;
            done_o   <= (len_i == '0);         // empty run ends at once
            state_q  <= (len_i == '0) ? st_idle : st_read;
          end else if (clear_i) begin
            done_o  <= 1'b0;
            error_o <= 1'b0;
          end
        end
        st_read: begin
          if (xfer_ack_i && xfer_err_i) begin  // abort, count untouched
            error_o <= 1'b1;
            done_o  <= 1'b1;
            state_q <= st_idle;
          end else if (xfer_ack_i) begin
            state_q <= st_write;
          end
        end
        st_write: begin
          if (xfer_ack_i && xfer_err_i) begin
            error_o <= 1'b1;
            done_o  <= 1'b1;
            state_q <= st_idle;
          end else if (xfer_ack_i) begin
            remain_q <= remain_q - len_w'(1);  // one more word landed
            state_q  <= st_finish;
          end
        end
        st_finish: begin
          if (remain_q == '0) begin
            done_o  <= 1'b1;
            state_q <= st_idle;
          end else begin
            state_q <= st_read;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // word pointers and read data
  always_ff @(posedge hclk_i) begin
    if (state_q == st_idle && start_i) begin
      rd_ptr_q <= {src_addr_i[addr_w-1:2], 2'b00}; // word aligned
      wr_ptr_q <= {dst_addr_i[addr_w-1:2], 2'b00};
    end else if (state_q == st_write && xfer_ack_i && !xfer_err_i) begin
      rd_ptr_q <= rd_ptr_q + 4;
      wr_ptr_q <= wr_ptr_q + 4;
    end
    if (state_q == st_read && xfer_ack_i && !xfer_err_i) begin
      data_q <= xfer_rdata_i;
    end
  end

  assign xfer_req_o   = (state_q == st_read) || (state_q == st_write);
  assign xfer_write_o = (state_q == st_write);
  assign xfer_addr_o  = xfer_write_o ? wr_ptr_q : rd_ptr_q;
  assign xfer_wdata_o = data_q;
  assign busy_o       = (state_q != st_idle);
  assign remaining_o  = remain_q;

  // an idle engine puts no request on the master port
  a_no_req_idle: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    (state_q == st_idle) |-> !xfer_req_o);

endmodule

`default_nettype wire

// ==== source/dma_ahb_master.sv ====
// dma AHB-Lite master
// runs one single word transfer at a time through its address and data phases
`timescale 1ns/1ps
`default_nettype none

module dma_ahb_master (
  input  logic                       hclk_i,
  input  logic                       arst_n_i,
  input  logic                       xfer_req_i,
  input  logic                       xfer_write_i,
  input  logic [dma_pkg::addr_w-1:0] xfer_addr_i,
  input  logic [dma_pkg::data_w-1:0] xfer_wdata_i,
  output logic                       xfer_ack_o,
  output logic [dma_pkg::data_w-1:0] xfer_rdata_o,
  output logic                       xfer_err_o,
  output logic [dma_pkg::addr_w-1:0] m_haddr_o,
  output logic [1:0]                 m_htrans_o,
  output logic                       m_hwrite_o,
  output logic [2:0]                 m_hsize_o,
  output logic [2:0]                 m_hburst_o,
  output logic [dma_pkg::data_w-1:0] m_hwdata_o,
  input  logic [dma_pkg::data_w-1:0] m_hrdata_i,
  input  logic                       m_hready_i,
  input  logic                       m_hresp_i
);
  import dma_pkg::*;

  logic              ap_q;                     // address phase on the bus
  logic              dp_q;                     // data phase on the bus
  logic              write_q;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] wdata_q;
  logic              take;                     // request accepted this cycle
  logic              dp_end;                   // data phase completes

  assign take   = xfer_req_i && !ap_q && !dp_q; // only one in flight
  assign dp_end = dp_q && m_hready_i;

  ////////////////////////////////////////////////////////////
  // phase tracker
  always_ff @(posedge hclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ap_q    <= 1'b0;
      dp_q    <= 1'b0;
      write_q <= 1'b0;
    end else begin
      if (take) begin
        ap_q    <= 1'b1;
        write_q <= xfer_write_i;
      end else if (ap_q && m_hready_i) begin
        ap_q <= 1'b0;                          // address accepted
      end
      if (ap_q && m_hready_i) begin
        dp_q <= 1'b1;
      end else if (dp_end) begin
        dp_q <= 1'b0;
      end
    end
  end

  // address and write data of the taken request
  always_ff @(posedge hclk_i) begin
    if (take) begin
      addr_q  <= xfer_addr_i;
      wdata_q <= xfer_wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus side
  assign m_haddr_o  = addr_q;
  assign m_htrans_o = ap_q ? htrans_nonseq : htrans_idle;
  assign m_hwrite_o = write_q;
  assign m_hsize_o  = hsize_word;              // words only
  assign m_hburst_o = hburst_single;
  assign m_hwdata_o = wdata_q;                 // held through the data phase

  // controller side, valid on the ack cycle
  assign xfer_ack_o   = dp_end;
  assign xfer_rdata_o = m_hrdata_i;
  assign xfer_err_o   = dp_end && (m_hresp_i == hresp_error);

  // a stalled address phase keeps its address and type
  a_ap_stable: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    ap_q && !m_hready_i |=> ap_q && $stable(m_haddr_o) && $stable(m_htrans_o)
                            && $stable(m_hwrite_o));

endmodule

`default_nettype wire

// ==== source/dma_subsystem.sv ====
// dma subsystem top
// CPU-side register slave, copy controller and memory-side AHB-Lite master
`timescale 1ns/1ps
`default_nettype none

module dma_subsystem (
  input  logic                       hclk_i,
  input  logic                       arst_n_i,
  // CPU slave bus
  input  logic                       hsel_i,
  input  logic [dma_pkg::addr_w-1:0] haddr_i,
  input  logic [1:0]                 htrans_i,
  input  logic                       hwrite_i,
  input  logic [dma_pkg::data_w-1:0] hwdata_i,
  input  logic                       hready_i,
  output logic [dma_pkg::data_w-1:0] hrdata_o,
  output logic                       hready_o,
  output logic                       hresp_o,
  // DMA master bus
  output logic [dma_pkg::addr_w-1:0] m_haddr_o,
  output logic [1:0]                 m_htrans_o,
  output logic                       m_hwrite_o,
  output logic [2:0]                 m_hsize_o,
  output logic [2:0]                 m_hburst_o,
  output logic [dma_pkg::data_w-1:0] m_hwdata_o,
  input  logic [dma_pkg::data_w-1:0] m_hrdata_i,
  input  logic                       m_hready_i,
  input  logic                       m_hresp_i
);
  import dma_pkg::*;

  ////////////////////////////////////////////////////////////
  // regs <-> ctrl
  logic              start;
  logic              clear;
  logic [addr_w-1:0] src_addr;
  logic [addr_w-1:0] dst_addr;
  logic [len_w-1:0]  len;
  logic              busy;
  logic              done;
  logic              error;
  logic [len_w-1:0]  remaining;

  // ctrl <-> master
  logic              xfer_req;
  logic              xfer_write;
  logic [addr_w-1:0] xfer_addr;
  logic [data_w-1:0] xfer_wdata;
  logic              xfer_ack;
  logic [data_w-1:0] xfer_rdata;
  logic              xfer_err;

  dma_regs u_regs (
    .hclk_i, .arst_n_i, .hsel_i, .haddr_i, .htrans_i, .hwrite_i, .hwdata_i, .hready_i,
    .hrdata_o, .hready_o, .hresp_o,
    .busy_i(busy), .done_i(done), .error_i(error), .remaining_i(remaining),
    .start_o(start), .clear_o(clear),
    .src_addr_o(src_addr), .dst_addr_o(dst_addr), .len_o(len)
  );

  dma_ctrl u_ctrl (
    .hclk_i, .arst_n_i,
    .start_i(start), .clear_i(clear),
    .src_addr_i(src_addr), .dst_addr_i(dst_addr), .len_i(len),
    .xfer_ack_i(xfer_ack), .xfer_rdata_i(xfer_rdata), .xfer_err_i(xfer_err),
    .xfer_req_o(xfer_req), .xfer_write_o(xfer_write),
    .xfer_addr_o(xfer_addr), .xfer_wdata_o(xfer_wdata),
    .busy_o(busy), .done_o(done), .error_o(error), .remaining_o(remaining)
  );

  dma_ahb_master u_master (
    .hclk_i, .arst_n_i,
    .xfer_req_i(xfer_req), .xfer_write_i(xfer_write),
    .xfer_addr_i(xfer_addr), .xfer_wdata_i(xfer_wdata),
    .xfer_ack_o(xfer_ack), .xfer_rdata_o(xfer_rdata), .xfer_err_o(xfer_err),
    .m_haddr_o, .m_htrans_o, .m_hwrite_o, .m_hsize_o, .m_hburst_o, .m_hwdata_o,
    .m_hrdata_i, .m_hready_i, .m_hresp_i
  );

endmodule

`default_nettype wire

// ==== tb/ahb_mem_model.sv ====
// AHB-Lite memory slave for the DMA master port
// 256 words, optional random wait states, error response at one address
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_model (
  input  logic        hclk_i,
  input  logic        arst_n_i,
  input  logic [31:0] haddr_i,
  input  logic [1:0]  htrans_i,
  input  logic        hwrite_i,
  input  logic [31:0] hwdata_i,
  output logic [31:0] hrdata_o,
  output logic        hready_o,
  output logic        hresp_o,
  input  logic        wait_en_i,               // random wait states in the data phase
  input  logic [31:0] err_addr_i,              // byte address that answers ERROR
  input  logic        bd_we_i,                 // backdoor load
  input  logic [7:0]  bd_idx_i,
  input  logic [31:0] bd_wdata_i,
  output logic [31:0] bd_rdata_o
);
  import dma_pkg::*;

  logic [31:0] mem [256];
  logic        dp_q;                           // data phase pending
  logic        wr_q;
  logic        err_q;                          // this data phase ends in ERROR
  logic        err2_q;                         // second cycle of the error response
  logic [7:0]  idx_q;
  int          wait_q;                         // wait states still to insert
  integer      wait_seed = 53;
  logic        err_now;

  assign err_now    = dp_q && err_q && (wait_q == 0);
  assign hready_o   = !dp_q || ((wait_q == 0) && (!err_q || err2_q));
  assign hresp_o    = err_now ? hresp_error : hresp_okay; // held over both cycles
  assign hrdata_o   = (dp_q && !wr_q && !err_q) ? mem[idx_q] : '0;
  assign bd_rdata_o = mem[bd_idx_i];

  always @(posedge hclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dp_q   <= 1'b0;
      wr_q   <= 1'b0;
      err_q  <= 1'b0;
      err2_q <= 1'b0;
      idx_q  <= '0;
      wait_q <= 0;
    end else begin
      if (bd_we_i) begin
        mem[bd_idx_i] <= bd_wdata_i;
      end
      if (dp_q && hready_o) begin              // data phase completes
        if (wr_q && !err_q) begin
          mem[idx_q] <= hwdata_i;
        end
        dp_q <= 1'b0;
      end else if (dp_q && wait_q != 0) begin
        wait_q <= wait_q - 1;
      end else if (err_now) begin
        err2_q <= 1'b1;                        // first ERROR cycle has hready low
      end
      if (hready_o && htrans_i == htrans_nonseq) begin
        dp_q   <= 1'b1;
        wr_q   <= hwrite_i;
        idx_q  <= haddr_i[9:2];
        err_q  <= (haddr_i == err_addr_i);
        err2_q <= 1'b0;
        wait_q <= wait_en_i ? ($random(wait_seed) & 3) : 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_dma_subsystem.sv ====
// testbench for the DMA subsystem
// programs copies over the CPU bus, checks status and memory from a row table
`timescale 1ns/1ps
`default_nettype none

module tb_dma_subsystem;
  import dma_pkg::*;

  typedef struct packed {
    logic [31:0] src;
    logic [31:0] dst;
    logic [3:0]  len;
    logic        waits;                        // random wait states on the memory
    logic        lockout;                      // poke the registers while busy
    logic [31:0] err_addr;                     // no_err for a clean run
  } row_t;

  localparam logic [31:0] no_err    = 32'hFFFF_FFFF;
  localparam logic [31:0] regs_base = 32'h4000_0000;

  logic        hclk;
  logic        arst_n;
  logic        hsel;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hwrite;
  logic [31:0] hwdata;
  logic        hready;
  logic [31:0] hrdata;
  logic        cpu_hready;
  logic        cpu_hresp;
  logic [31:0] m_haddr;
  logic [1:0]  m_htrans;
  logic        m_hwrite;
  logic [2:0]  m_hsize;
  logic [2:0]  m_hburst;
  logic [31:0] m_hwdata;
  logic [31:0] m_hrdata;
  logic        m_hready;
  logic        m_hresp;
  logic        wait_en;
  logic [31:0] err_addr;
  logic        bd_we;
  logic [7:0]  bd_idx;
  logic [31:0] bd_wdata;
  logic [31:0] bd_rdata;

  logic [31:0] exp_mem [256];                  // reference image of the memory
  row_t        rows [$];
  integer      seed;
  int          errors;
  int          failed_tests;
  int          n_tests;

  dma_subsystem dut (
    .hclk_i(hclk), .arst_n_i(arst_n),
    .hsel_i(hsel), .haddr_i(haddr), .htrans_i(htrans), .hwrite_i(hwrite),
    .hwdata_i(hwdata), .hready_i(hready),
    .hrdata_o(hrdata), .hready_o(cpu_hready), .hresp_o(cpu_hresp),
    .m_haddr_o(m_haddr), .m_htrans_o(m_htrans), .m_hwrite_o(m_hwrite),
    .m_hsize_o(m_hsize), .m_hburst_o(m_hburst), .m_hwdata_o(m_hwdata),
    .m_hrdata_i(m_hrdata), .m_hready_i(m_hready), .m_hresp_i(m_hresp)
  );

  ahb_mem_model mem_model (
    .hclk_i(hclk), .arst_n_i(arst_n),
    .haddr_i(m_haddr), .htrans_i(m_htrans), .hwrite_i(m_hwrite), .hwdata_i(m_hwdata),
    .hrdata_o(m_hrdata), .hready_o(m_hready), .hresp_o(m_hresp),
    .wait_en_i(wait_en), .err_addr_i(err_addr),
    .bd_we_i(bd_we), .bd_idx_i(bd_idx), .bd_wdata_i(bd_wdata), .bd_rdata_o(bd_rdata)
  );

  always #50 hclk = ~hclk;

  // master side only ever issues single aligned words
  always @(posedge hclk) begin
    if (arst_n && m_htrans == htrans_nonseq) begin
      assert (m_hsize == hsize_word && m_hburst == hburst_single && m_haddr[1:0] == 2'b00)
        else begin
          $display("FAILED m_hsize_o/m_hburst_o/m_haddr_o: %h %h %08h, expected 2 0 aligned",
                   m_hsize, m_hburst, m_haddr);
          errors++;
        end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks and CPU bus cycles, entered just after a rising edge
  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got %08h, expected %08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [3:0] off, input logic [31:0] data);
    hsel   = 1'b1;                             // address phase
    haddr  = regs_base | {28'h0, off};
    htrans = htrans_nonseq;
    hwrite = 1'b1;
    @(posedge hclk);
    #10;
    hsel   = 1'b0;                             // data phase
    htrans = htrans_idle;
    hwrite = 1'b0;
    hwdata = data;
    expect_eq("hready_o", {31'h0, cpu_hready}, 32'h1);
    expect_eq("hresp_o", {31'h0, cpu_hresp}, 32'h0);
    @(posedge hclk);
    #10;
  endtask

  task automatic read_reg(input logic [3:0] off, output logic [31:0] data);
    hsel   = 1'b1;
    haddr  = regs_base | {28'h0, off};
    htrans = htrans_nonseq;
    hwrite = 1'b0;
    @(posedge hclk);
    #10;
    hsel   = 1'b0;
    htrans = htrans_idle;
    data   = hrdata;                           // valid in the data phase
    @(posedge hclk);
    #10;
  endtask

  // busy in bit 0, done 1, error 2, words left in 7:4
  function automatic logic [31:0] status_word(input logic busy, input logic done,
                                              input logic err, input logic [3:0] rem);
    return {24'h0, rem, 1'b0, err, done, busy};
  endfunction

  task automatic wait_for_status(input int bit_idx, input string what,
                                 output logic [31:0] status);
    int polls;
    polls = 0;
    read_reg(reg_ctrl_off, status);
    while (!status[bit_idx] && polls < 400) begin
      read_reg(reg_ctrl_off, status);
      polls++;
    end
    if (!status[bit_idx]) begin
      $display("timeout: %s bit still clear after %0d status reads", what, polls);
      errors++;
    end
  endtask

  task automatic fill_memory();
    logic [31:0] word;
    for (int i = 0; i < 256; i++) begin
      word       = $random(seed);
      exp_mem[i] = word;
      bd_we      = 1'b1;
      bd_idx     = 8'(i);
      bd_wdata   = word;
      @(posedge hclk);
      #10;
    end
    bd_we = 1'b0;
  endtask

  task automatic compare_memory();
    for (int i = 0; i < 256; i++) begin
      bd_idx = 8'(i);
      #1;
      expect_eq($sformatf("mem[%02h]", i), bd_rdata, exp_mem[i]);
    end
    @(posedge hclk);
    #10;
  endtask

  task automatic add_row(input logic [31:0] src, input logic [31:0] dst, input logic [3:0] len,
                         input logic waits, input logic lockout, input logic [31:0] err);
    row_t row;
    row = '{src, dst, len, waits, lockout, err};
    rows.push_back(row);
  endtask

  ////////////////////////////////////////////////////////////
  // one table row, from memory fill to readback
  task automatic run_copy(input row_t row);
    logic [31:0] status;
    logic [31:0] rd;
    int          src_idx;
    int          dst_idx;
    int          k;                            // words that land before any error
    src_idx  = int'(row.src[9:2]);
    dst_idx  = int'(row.dst[9:2]);
    k        = (row.err_addr == no_err) ? int'(row.len) : int'((row.err_addr - row.src) >> 2);
    wait_en  = row.waits;
    err_addr = row.err_addr;
    fill_memory();
    write_reg(reg_ctrl_off, 32'h2);            // drop done and error of the last run
    read_reg(reg_ctrl_off, status);
    expect_eq("status[2:1]", {30'h0, status[2:1]}, 32'h0);
    write_reg(reg_src_off, row.src);
    write_reg(reg_dst_off, row.dst);
    write_reg(reg_len_off, {28'h0, row.len});
    write_reg(reg_ctrl_off, 32'h1);
    if (row.lockout) begin
      wait_for_status(0, "busy", status);
      write_reg(reg_src_off, 32'h0000_03F0);   // all of these must bounce off
      write_reg(reg_dst_off, 32'h0000_0000);
      write_reg(reg_len_off, 32'h0000_0003);
      write_reg(reg_ctrl_off, 32'h1);
      read_reg(reg_ctrl_off, status);
      expect_eq("busy", {31'h0, status[0]}, 32'h1);
    end
    wait_for_status(1, "done", status);
    expect_eq("status", status,
              status_word(1'b0, 1'b1, row.err_addr != no_err, 4'(int'(row.len) - k)));
    for (int i = 0; i < k; i++) begin
      exp_mem[dst_idx + i] = exp_mem[src_idx + i]; // ascending word copy
    end
    compare_memory();
    if (row.lockout) begin
      read_reg(reg_src_off, rd);
      expect_eq("src_addr", rd, row.src);
      read_reg(reg_dst_off, rd);
      expect_eq("dst_addr", rd, row.dst);
      read_reg(reg_len_off, rd);
      expect_eq("len", rd, {28'h0, row.len});
    end
  endtask

  task automatic close_test(input string what, input int errs_before);
    n_tests++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", n_tests, what);
    end else begin
      failed_tests++;
      $display("test %0d %s: failed", n_tests, what);
    end
  endtask

  initial begin
    logic [31:0] rd;
    int          errs_before;
    hclk     = 1'b0;
    arst_n   = 1'b0;
    hsel     = 1'b0;
    haddr    = '0;
    htrans   = htrans_idle;
    hwrite   = 1'b0;
    hwdata   = '0;
    hready   = 1'b1;                           // single master on the CPU bus
    wait_en  = 1'b0;
    err_addr = no_err;
    bd_we    = 1'b0;
    bd_idx   = '0;
    bd_wdata = '0;
    seed     = 53;
    errors   = 0;
    failed_tests = 0;
    n_tests  = 0;
    repeat (5) @(posedge hclk);
    #10;
    arst_n = 1'b1;
    @(posedge hclk);
    #10;

    // register access and reset values
    errs_before = errors;
    read_reg(reg_ctrl_off, rd);
    expect_eq("status", rd, 32'h0);
    read_reg(reg_src_off, rd);
    expect_eq("src_addr", rd, 32'h0);
    write_reg(reg_src_off, 32'hA5A5_1234);
    write_reg(reg_dst_off, 32'h0000_0FFC);
    write_reg(reg_len_off, 32'h0000_0039);     // only the low 4 bits are kept
    read_reg(reg_src_off, rd);
    expect_eq("src_addr", rd, 32'hA5A5_1234);
    read_reg(reg_dst_off, rd);
    expect_eq("dst_addr", rd, 32'h0000_0FFC);
    read_reg(reg_len_off, rd);
    expect_eq("len", rd, 32'h0000_0009);
    close_test("register access", errs_before);

    //     src      dst      len    waits lockout error address
    add_row(32'h000, 32'h100, 4'd8,  1'b0, 1'b0, no_err);
    add_row(32'h040, 32'h200, 4'd0,  1'b0, 1'b0, no_err);
    add_row(32'h000, 32'h100, 4'd8,  1'b1, 1'b0, no_err);
    add_row(32'h080, 32'h300, 4'd15, 1'b1, 1'b0, no_err);
    add_row(32'h020, 32'h180, 4'd10, 1'b0, 1'b0, 32'h030); // word 4 of the source
    add_row(32'h0C0, 32'h280, 4'd6,  1'b1, 1'b0, 32'h0C0); // first read fails
    add_row(32'h010, 32'h340, 4'd12, 1'b1, 1'b1, no_err);

    foreach (rows[r]) begin
      errs_before = errors;
      run_copy(rows[r]);
      close_test($sformatf("src %03h dst %03h len %0d waits %0b lockout %0b err %08h",
                           rows[r].src, rows[r].dst, rows[r].len, rows[r].waits,
                           rows[r].lockout, rows[r].err_addr), errs_before);
    end

    $display("summary: %0d tests, %0d failed, %0d failed checks",
             n_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/dma_pkg.sv
source/dma_regs.sv
source/dma_ctrl.sv
source/dma_ahb_master.sv
source/dma_subsystem.sv
tb/ahb_mem_model.sv
tb/tb_dma_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# build the DMA subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_dma_subsystem -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dma_subsystem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^=== PASS ===$"; then
  exit 0
fi
exit 1
